// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_mcd_host_bridge
FILELIST   = verilog.f
BUILD_DIR  = obj_dir
PASS_MSG   = === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The simulation fails unless its output holds the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/aspect_ratio.sv ====
/*
 * HDMI aspect ratio selection.
 * The active resolution is locked at the end of each vertical blank,
 * so the ratio can only change between frames. The numbers follow the
 * 16:9 and corrected-aspect options.
 */
`timescale 1ns/100ps

module aspect_ratio (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                vblank,
	input  mcd_pkg::video_res_e resolution,
	input  logic                wide_169,
	input  logic                ar_corrected,
	output logic [7:0]          video_arx,
	output logic [7:0]          video_ary
);
	import mcd_pkg::*;

	logic       vblank_q;
	video_res_e res_lock;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			vblank_q <= 1'b0;
			res_lock <= RES_H32_V28;
		end else begin
			vblank_q <= vblank;
			if (vblank_q && !vblank)
				res_lock <= resolution;
		end
	end

	////////////////////////////////////////
	// Ratio table
	////////////////////////////////////////
	always_comb begin
		if (wide_169) begin
			video_arx = 8'd16;
			video_ary = 8'd9;
		end else begin
			case (res_lock)
				// 256x224
				RES_H32_V28: begin
					video_arx = 8'd64;
					video_ary = 8'd49;
				end
				// 320x224
				RES_H40_V28: begin
					video_arx = ar_corrected ? 8'd10 : 8'd64;
					video_ary = ar_corrected ? 8'd7 : 8'd49;
				end
				// 256x240
				RES_H32_V30: begin
					video_arx = 8'd128;
					video_ary = 8'd105;
				end
				// 320x240
				default: begin
					video_arx = ar_corrected ? 8'd4 : 8'd128;
					video_ary = ar_corrected ? 8'd3 : 8'd105;
				end
			endcase
		end
	end

endmodule

// ==== hw/cdc_write_stretch.sv ====
/*
 * CD data and subcode write stretcher.
 * Every CDC data or subcode download word is latched and its strobe is
 * held long enough for the slower CD controller to catch it. A new
 * write restarts the hold.
 */
`timescale 1ns/100ps
`include "mcd_config.svh"

module cdc_write_stretch (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  logic                      dl_active,
	input  logic                      dl_wr,
	input  logic [7:0]                dl_index,
	input  logic [`MCD_DL_DATA_W-1:0] dl_data,
	output logic [`MCD_DL_DATA_W-1:0] cdc_data,
	output logic                      cdc_dat_wr,
	output logic                      cdc_sc_wr
);
	import mcd_pkg::*;

	localparam int CNT_W = $clog2(`MCD_HOLD_CYCLES + 1);

	dl_kind_e         kind;
	logic             dat_wr;
	logic             sub_wr;
	logic [CNT_W-1:0] hold_cnt;

	assign kind   = dl_kind_of(dl_index);
	assign dat_wr = dl_active & dl_wr & (kind == DL_CDC_DAT);
	assign sub_wr = dl_active & dl_wr & (kind == DL_CDC_SUB);

	always_ff @(posedge clk_sys) begin
		if (dat_wr || sub_wr)
			cdc_data <= dl_data;
	end

	// Strobe registers also record which kind came last
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cdc_dat_wr <= 1'b0;
			cdc_sc_wr  <= 1'b0;
			hold_cnt   <= '0;
		end else if (dat_wr || sub_wr) begin
			cdc_dat_wr <= dat_wr;
			cdc_sc_wr  <= sub_wr;
			hold_cnt   <= CNT_W'(`MCD_HOLD_CYCLES);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end else begin
			cdc_dat_wr <= 1'b0;
			cdc_sc_wr  <= 1'b0;
		end
	end

endmodule

// ==== hw/cdd_link.sv ====
/*
 * CD drive message exchange with the host.
 * The host flips bit 48 of cd_out to deliver a new status word, which
 * is latched and announced by a stretched cdd_rec pulse. A rising
 * cdd_send copies the drive command into cd_in and flips its toggle.
 */
`timescale 1ns/100ps
`include "mcd_config.svh"

module cdd_link (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic [`MCD_CD_LINK_W-1:0]  cd_out,
	input  logic [`MCD_CDD_STAT_W-1:0] cdd_comm,
	input  logic                       cdd_send,
	output logic [`MCD_CDD_STAT_W-1:0] cdd_stat,
	output logic                       cdd_dm,
	output logic                       cdd_rec,
	output logic [`MCD_CD_LINK_W-1:0]  cd_in
);

	localparam int TOG   = `MCD_CD_LINK_W - 1;
	localparam int PAD_W = `MCD_CD_LINK_W - 1 - `MCD_CDD_STAT_W;
	localparam int CNT_W = $clog2(`MCD_HOLD_CYCLES + 1);

	logic             tog_seen;
	logic             new_stat;
	logic [CNT_W-1:0] rec_cnt;
	logic             send_q;

	assign new_stat = cd_out[TOG] != tog_seen;

	////////////////////////////////////////
	// Host to drive status
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (new_stat) begin
			cdd_stat <= cd_out[`MCD_CDD_STAT_W-1:0];
			cdd_dm   <= cd_out[`MCD_CDD_STAT_W];
		end
	end

	// cdd_rec stays up one cycle past the count
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			tog_seen <= 1'b0;
			cdd_rec  <= 1'b0;
			rec_cnt  <= '0;
		end else begin
			if (new_stat) begin
				tog_seen <= cd_out[TOG];
				cdd_rec  <= 1'b1;
				rec_cnt  <= CNT_W'(`MCD_HOLD_CYCLES);
			end else if (rec_cnt != '0) begin
				rec_cnt <= rec_cnt - 1'b1;
			end else begin
				cdd_rec <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// Drive to host command
	////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			send_q <= 1'b0;
			cd_in  <= '0;
		end else begin
			send_q <= cdd_send;
			if (cdd_send && !send_q) begin
				cd_in[TOG-1:0] <= {{PAD_W{1'b0}}, cdd_comm};
				cd_in[TOG]     <= ~cd_in[TOG];
			end
		end
	end

endmodule

// ==== hw/cheat_code_loader.sv ====
/*
 * Cheat entry assembler.
 * Collects the eight 16-bit words of a cheat download into one entry
 * and pulses the strobe of the console side that owns the address.
 * A write at offset zero asks both sides to drop their cheats.
 */
`timescale 1ns/100ps
`include "mcd_config.svh"

module cheat_code_loader (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  logic                      dl_active,
	input  logic                      dl_wr,
	input  logic [7:0]                dl_index,
	input  logic [`MCD_DL_ADDR_W-1:0] dl_addr,
	input  logic [`MCD_DL_DATA_W-1:0] dl_data,
	output mcd_pkg::cheat_code_t      code,
	output logic                      code_gen_stb,
	output logic                      code_mcd_stb,
	output logic                      code_clear
);
	import mcd_pkg::*;

	logic code_wr;
	logic last_word;

	assign code_wr   = dl_active & dl_wr & (dl_kind_of(dl_index) == DL_CODE);
	assign last_word = code_wr & (dl_addr[3:0] == 4'd14);

	// Bottom word of each field arrives first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl_addr[3:0])
				4'd0:    code.flags[15:0]    <= dl_data;
				4'd2:    code.flags[31:16]   <= dl_data;
				4'd4:    code.addr[15:0]     <= dl_data;
				4'd6:    code.addr[31:16]    <= dl_data;
				4'd8:    code.compare[15:0]  <= dl_data;
				4'd10:   code.compare[31:16] <= dl_data;
				4'd12:   code.replace[15:0]  <= dl_data;
				4'd14:   code.replace[31:16] <= dl_data;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// Strobes
	////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			code_gen_stb <= 1'b0;
			code_mcd_stb <= 1'b0;
			code_clear   <= 1'b0;
		end else begin
			// Side bit was written with the address top word
			code_mcd_stb <= last_word & code.addr[`MCD_SIDE_BIT];
			code_gen_stb <= last_word & ~code.addr[`MCD_SIDE_BIT];
			code_clear   <= code_wr & (dl_addr == '0);
		end
	end

endmodule

// ==== hw/mcd_host_bridge.sv ====
/*
 * Host side support for the CD-equipped console core.
 * Joins the cheat loader, region selector, CD drive link, CD write
 * stretcher and aspect ratio selector to the host download bus, the
 * keyboard, the CD link words and the video timing.
 */
`timescale 1ns/100ps
`include "mcd_config.svh"

module mcd_host_bridge (
	input  logic                       clk_sys,
	input  logic                       rst_n,

	// Host download bus
	input  logic                       dl_active,
	input  logic                       dl_wr,
	input  logic [7:0]                 dl_index,
	input  logic [`MCD_DL_ADDR_W-1:0]  dl_addr,
	input  logic [`MCD_DL_DATA_W-1:0]  dl_data,

	input  logic [`MCD_PS2_W-1:0]      ps2_key,

	// CD link
	input  logic [`MCD_CD_LINK_W-1:0]  cd_out,
	input  logic [`MCD_CDD_STAT_W-1:0] cdd_comm,
	input  logic                       cdd_send,

	// Video and options
	input  logic                       vblank,
	input  mcd_pkg::video_res_e        resolution,
	input  logic                       wide_169,
	input  logic                       ar_corrected,

	output mcd_pkg::cheat_code_t       code,
	output logic                       code_gen_stb,
	output logic                       code_mcd_stb,
	output logic                       code_clear,

	output mcd_pkg::region_e           region_req,
	output logic                       region_set,

	output logic [`MCD_CDD_STAT_W-1:0] cdd_stat,
	output logic                       cdd_dm,
	output logic                       cdd_rec,
	output logic [`MCD_CD_LINK_W-1:0]  cd_in,

	output logic [`MCD_DL_DATA_W-1:0]  cdc_data,
	output logic                       cdc_dat_wr,
	output logic                       cdc_sc_wr,

	output logic [7:0]                 video_arx,
	output logic [7:0]                 video_ary
);

	////////////////////////////////////////
	// Download consumers
	////////////////////////////////////////
	cheat_code_loader i_cheat_code_loader (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.dl_index     (dl_index),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.code         (code),
		.code_gen_stb (code_gen_stb),
		.code_mcd_stb (code_mcd_stb),
		.code_clear   (code_clear)
	);

	region_select i_region_select (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.dl_active  (dl_active),
		.dl_wr      (dl_wr),
		.dl_index   (dl_index),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.ps2_key    (ps2_key),
		.region_req (region_req),
		.region_set (region_set)
	);

	cdc_write_stretch i_cdc_write_stretch (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.dl_active  (dl_active),
		.dl_wr      (dl_wr),
		.dl_index   (dl_index),
		.dl_data    (dl_data),
		.cdc_data   (cdc_data),
		.cdc_dat_wr (cdc_dat_wr),
		.cdc_sc_wr  (cdc_sc_wr)
	);

	////////////////////////////////////////
	// CD drive and video
	////////////////////////////////////////
	cdd_link i_cdd_link (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.cd_out   (cd_out),
		.cdd_comm (cdd_comm),
		.cdd_send (cdd_send),
		.cdd_stat (cdd_stat),
		.cdd_dm   (cdd_dm),
		.cdd_rec  (cdd_rec),
		.cd_in    (cd_in)
	);

	aspect_ratio i_aspect_ratio (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.vblank       (vblank),
		.resolution   (resolution),
		.wide_169     (wide_169),
		.ar_corrected (ar_corrected),
		.video_arx    (video_arx),
		.video_ary    (video_ary)
	);

endmodule

// ==== hw/mcd_pkg.sv ====
/*
 * Types shared by the host bridge blocks.
 * Region, download kind and video resolution enums, the cheat entry
 * layout and the classifier of the host download index.
 */
package mcd_pkg;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

	typedef enum logic [2:0] {
		DL_BIOS,
		DL_CDC_DAT,
		DL_CDC_SUB,
		DL_CART,
		DL_SAVE,
		DL_CODE,
		DL_OTHER
	} dl_kind_e;

	// Bit 0 is H40, bit 1 is V30
	typedef enum logic [1:0] {
		RES_H32_V28 = 2'b00,
		RES_H40_V28 = 2'b01,
		RES_H32_V30 = 2'b10,
		RES_H40_V30 = 2'b11
	} video_res_e;

	// Fields stay big-endian, as the host hands them over
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	function automatic dl_kind_e dl_kind_of(input logic [7:0] index);
		dl_kind_e kind;
		if (&index)                kind = DL_CODE;
		else if (index[5:0] <= 6'h01) kind = DL_BIOS;
		else if (index[5:0] == 6'h02) kind = DL_CDC_DAT;
		else if (index[5:0] == 6'h03) kind = DL_CDC_SUB;
		else if (index[5:0] == 6'h04) kind = DL_CART;
		else if (index[5:0] == 6'h05) kind = DL_SAVE;
		else                       kind = DL_OTHER;
		return kind;
	endfunction

endpackage

// ==== hw/region_select.sv ====
/*
 * Console region selection.
 * Reads the region letter from the cartridge header while a ROM is
 * downloaded and requests the matching region, holding region_set for
 * the rest of the download. F1, F2 and F3 pick JP, US and EU by hand.
 */
`timescale 1ns/100ps
`include "mcd_config.svh"

module region_select (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  logic                      dl_active,
	input  logic                      dl_wr,
	input  logic [7:0]                dl_index,
	input  logic [`MCD_DL_ADDR_W-1:0] dl_addr,
	input  logic [`MCD_DL_DATA_W-1:0] dl_data,
	input  logic [`MCD_PS2_W-1:0]     ps2_key,
	output mcd_pkg::region_e          region_req,
	output logic                      region_set
);
	import mcd_pkg::*;

	localparam logic [`MCD_DL_ADDR_W-1:0] HDR_ADDR = `MCD_HDR_REGION_ADDR;
	localparam int KEY_TOG     = `MCD_PS2_W - 1;
	localparam int KEY_PRESSED = `MCD_PS2_W - 2;

	dl_kind_e kind;
	logic     rom_dl;
	logic     rom_dl_q;
	logic     hdr_wr;
	logic     hdr_j;
	logic     hdr_u;
	logic     hdr_ready;
	logic     ready_q;
	logic     key_tog_q;

	assign kind   = dl_kind_of(dl_index);
	assign rom_dl = dl_active & ((kind == DL_BIOS) | (kind == DL_CART));
	assign hdr_wr = rom_dl & dl_wr & (dl_addr == HDR_ADDR);

	////////////////////////////////////////
	// Cartridge header
	////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rom_dl_q  <= 1'b0;
			hdr_j     <= 1'b0;
			hdr_u     <= 1'b0;
			hdr_ready <= 1'b0;
		end else begin
			rom_dl_q <= rom_dl;
			// New ROM, forget the previous header
			if (rom_dl && !rom_dl_q) begin
				hdr_j     <= 1'b0;
				hdr_u     <= 1'b0;
				hdr_ready <= 1'b0;
			end
			if (!rom_dl && rom_dl_q)
				hdr_ready <= 1'b0;
			if (hdr_wr) begin
				if (dl_data[7:0] == "J")
					hdr_j <= 1'b1;
				else if (dl_data[7:0] == "U")
					hdr_u <= 1'b1;
				hdr_ready <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Region request
	////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			key_tog_q  <= 1'b0;
			ready_q    <= 1'b0;
			region_req <= REGION_JP;
			region_set <= 1'b0;
		end else begin
			key_tog_q <= ps2_key[KEY_TOG];
			if (key_tog_q != ps2_key[KEY_TOG]) begin
				case (ps2_key[8:0])
					`MCD_KEY_F1: begin
						region_req <= REGION_JP;
						region_set <= ps2_key[KEY_PRESSED];
					end
					`MCD_KEY_F2: begin
						region_req <= REGION_US;
						region_set <= ps2_key[KEY_PRESSED];
					end
					`MCD_KEY_F3: begin
						region_req <= REGION_EU;
						region_set <= ps2_key[KEY_PRESSED];
					end
					default: ;
				endcase
			end

			// Header wins over a key in the same cycle
			ready_q <= hdr_ready;
			if (!ready_q && hdr_ready) begin
				region_set <= 1'b1;
				if (hdr_u)
					region_req <= REGION_US;
				else if (hdr_j)
					region_req <= REGION_JP;
				else
					region_req <= REGION_EU;
			end
			if (ready_q && !hdr_ready)
				region_set <= 1'b0;
		end
	end

endmodule

// ==== include/mcd_config.svh ====
/*
 * Shared constants for the host bridge core.
 * Bus widths, cartridge header offset, keyboard scan codes and the
 * length of the stretched strobes. Include it in any file that sizes
 * a port or compares against one of these values.
 */
`ifndef MCD_CONFIG_SVH
`define MCD_CONFIG_SVH

////////////////////////////////////////
// Host download bus
////////////////////////////////////////
`define MCD_DL_DATA_W 16
`define MCD_DL_ADDR_W 25

// Byte offset of the region letter in the cartridge header
`define MCD_HDR_REGION_ADDR 'h1F0

// Address bit of a cheat entry that routes it to the CD side
`define MCD_SIDE_BIT 31

////////////////////////////////////////
// CD drive link
////////////////////////////////////////
`define MCD_CDD_STAT_W 40
// Bit 48 carries the toggle
`define MCD_CD_LINK_W 49

// Receive pulse and CD write strobe length
`define MCD_HOLD_CYCLES 8

////////////////////////////////////////
// Keyboard
////////////////////////////////////////
// {toggle, pressed, code[8:0]}
`define MCD_PS2_W 11
`define MCD_KEY_F1 9'h005
`define MCD_KEY_F2 9'h006
`define MCD_KEY_F3 9'h004

`endif

// ==== tests/tb_clock.sv ====
/*
 * Clock and reset source for the testbench.
 * Runs clk_sys with an 8 ns period and holds rst_n low for the first
 * 8 cycles, then releases it between two rising edges.
 */
`timescale 1ns/100ps

module tb_clock (
	output logic clk_sys,
	output logic rst_n
);
	localparam real HALF_PERIOD = 4.0;

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD) clk_sys = ~clk_sys;
	end

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
	end

endmodule

// ==== tests/tb_mcd_host_bridge.sv ====
/*
 * Directed testbench for the host bridge core.
 * Runs cheat download, header region, hotkey, CD link, CDC write
 * stretch and aspect ratio tests against the top level. Inputs change
 * on the rising edge, outputs are checked on the falling edge.
 */
`timescale 1ns/100ps
`include "mcd_config.svh"

module tb_mcd_host_bridge;
	import mcd_pkg::*;

	localparam int TIMEOUT_CYCLES = 2000;
	localparam logic [7:0] IDX_CDC_DAT = 8'h02;
	localparam logic [7:0] IDX_CDC_SUB = 8'h03;
	localparam logic [7:0] IDX_CART    = 8'h04;
	localparam logic [7:0] IDX_CODE    = 8'hFF;

	// Positions in the watch vector
	localparam logic [2:0] SEL_SC    = 3'd0;
	localparam logic [2:0] SEL_DAT   = 3'd1;
	localparam logic [2:0] SEL_REC   = 3'd2;
	localparam logic [2:0] SEL_RSET  = 3'd3;
	localparam logic [2:0] SEL_MCD   = 3'd4;
	localparam logic [2:0] SEL_GEN   = 3'd5;

	logic                       clk_sys;
	logic                       rst_n;
	logic                       dl_active;
	logic                       dl_wr;
	logic [7:0]                 dl_index;
	logic [`MCD_DL_ADDR_W-1:0]  dl_addr;
	logic [`MCD_DL_DATA_W-1:0]  dl_data;
	logic [`MCD_PS2_W-1:0]      ps2_key;
	logic [`MCD_CD_LINK_W-1:0]  cd_out;
	logic [`MCD_CDD_STAT_W-1:0] cdd_comm;
	logic                       cdd_send;
	logic                       vblank;
	video_res_e                 resolution;
	logic                       wide_169;
	logic                       ar_corrected;
	cheat_code_t                code;
	logic                       code_gen_stb;
	logic                       code_mcd_stb;
	logic                       code_clear;
	region_e                    region_req;
	logic                       region_set;
	logic [`MCD_CDD_STAT_W-1:0] cdd_stat;
	logic                       cdd_dm;
	logic                       cdd_rec;
	logic [`MCD_CD_LINK_W-1:0]  cd_in;
	logic [`MCD_DL_DATA_W-1:0]  cdc_data;
	logic                       cdc_dat_wr;
	logic                       cdc_sc_wr;
	logic [7:0]                 video_arx;
	logic [7:0]                 video_ary;

	logic [5:0]  watch;
	logic [31:0] lcg_state = 32'd72979;
	int          value_errors = 0;
	int          other_errors = 0;
	int          cycle_count = 0;
	int          gen_pulses = 0;
	int          mcd_pulses = 0;
	int          clear_pulses = 0;

	assign watch = {code_gen_stb, code_mcd_stb, region_set,
		cdd_rec, cdc_dat_wr, cdc_sc_wr};

	tb_clock i_tb_clock (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	mcd_host_bridge i_mcd_host_bridge (.*);

	////////////////////////////////////////
	// Monitors and timeout
	////////////////////////////////////////
	always @(negedge clk_sys) begin
		if (rst_n) begin
			if (code_clear)
				clear_pulses <= clear_pulses + 1;
			if (code_gen_stb)
				gen_pulses <= gen_pulses + 1;
			if (code_mcd_stb)
				mcd_pulses <= mcd_pulses + 1;
		end
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			print_counts();
			$display("=== FAIL ===");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Ratio table, H40 is bit 0 and V30 is bit 1
	function automatic logic [15:0] expected_ratio(input video_res_e res, input logic corr,
		input logic wide);
		logic h40;
		logic v30;
		h40 = res[0];
		v30 = res[1];
		if (wide)
			return {8'd16, 8'd9};
		if (v30)
			return (h40 && corr) ? {8'd4, 8'd3} : {8'd128, 8'd105};
		return (h40 && corr) ? {8'd10, 8'd7} : {8'd64, 8'd49};
	endfunction

	task automatic print_counts();
		$display("Results: %0d value errors, %0d other failures", value_errors, other_errors);
	endtask

	task automatic init_inputs();
		dl_active    <= 1'b0;
		dl_wr        <= 1'b0;
		dl_index     <= 8'h00;
		dl_addr      <= '0;
		dl_data      <= '0;
		ps2_key      <= '0;
		cd_out       <= '0;
		cdd_comm     <= '0;
		cdd_send     <= 1'b0;
		vblank       <= 1'b0;
		resolution   <= RES_H32_V28;
		wide_169     <= 1'b0;
		ar_corrected <= 1'b0;
	endtask

	task automatic dl_begin(input logic [7:0] index);
		@(posedge clk_sys);
		dl_index  <= index;
		dl_active <= 1'b1;
	endtask

	task automatic dl_end();
		@(posedge clk_sys);
		dl_active <= 1'b0;
	endtask

	// One-cycle write, returns on the edge that samples it
	task automatic dl_write(input logic [`MCD_DL_ADDR_W-1:0] addr,
		input logic [`MCD_DL_DATA_W-1:0] data);
		@(posedge clk_sys);
		dl_wr   <= 1'b1;
		dl_addr <= addr;
		dl_data <= data;
		@(posedge clk_sys);
		dl_wr <= 1'b0;
	endtask

	task automatic wait_level(input string test, input string sig, input logic [2:0] sel,
		input logic level, input int limit);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (watch[sel] !== level && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (watch[sel] !== level) begin
			$display("Failure in %s: %s did not go to %b within %0d cycles",
				test, sig, level, limit);
			other_errors++;
		end
	endtask

	// Counts falling edges with the flag high, starting at the current one
	task automatic pulse_width(input logic [2:0] sel, output int width);
		width = 0;
		while (watch[sel] === 1'b1 && width < 32) begin
			width++;
			@(negedge clk_sys);
		end
	endtask

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////
	task automatic check_bit(input string test, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error %s: expected %b, actual %b", test, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_count(input string test, input int exp, input int act);
		if (act != exp) begin
			$display("Error %s: expected %0d, actual %0d", test, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_code(input string test, input cheat_code_t exp, input cheat_code_t act);
		if (act !== exp) begin
			$display("Error %s: expected %h, actual %h", test, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_region(input string test, input region_e exp, input region_e act);
		if (act !== exp) begin
			$display("Error %s: expected %s, actual %s", test, exp.name(), act.name());
			value_errors++;
		end
	endtask

	task automatic check_word(input string test, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("Error %s: expected %h, actual %h", test, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_stat(input string test, input logic [39:0] exp, input logic [39:0] act);
		if (act !== exp) begin
			$display("Error %s: expected %h, actual %h", test, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_link(input string test, input logic [48:0] exp, input logic [48:0] act);
		if (act !== exp) begin
			$display("Error %s: expected %h, actual %h", test, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_ratio(input string test, input logic [7:0] exp_x,
		input logic [7:0] exp_y, input logic [7:0] act_x, input logic [7:0] act_y);
		if (act_x !== exp_x || act_y !== exp_y) begin
			$display("Error %s: expected %0d:%0d, actual %0d:%0d",
				test, exp_x, exp_y, act_x, act_y);
			value_errors++;
		end
	endtask

	task automatic expect_ratio(input video_res_e res, input logic corr, input logic wide);
		logic [15:0] e;
		e = expected_ratio(res, corr, wide);
		check_ratio("aspect", e[15:8], e[7:0], video_arx, video_ary);
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////
	task automatic check_reset_state();
		@(negedge clk_sys);
		check_bit("reset", 1'b0, code_gen_stb);
		check_bit("reset", 1'b0, code_mcd_stb);
		check_bit("reset", 1'b0, code_clear);
		check_bit("reset", 1'b0, cdd_rec);
		check_bit("reset", 1'b0, cdc_dat_wr);
		check_bit("reset", 1'b0, cdc_sc_wr);
		check_bit("reset", 1'b0, region_set);
		check_link("reset", '0, cd_in);
		check_ratio("reset", 8'd64, 8'd49, video_arx, video_ary);
	endtask

	task automatic test_cheat(input logic side);
		logic [15:0] w [8];
		logic [31:0] r;
		cheat_code_t exp;
		int gen0;
		int mcd0;
		int clr0;
		int i;
		for (i = 0; i < 8; i++) begin
			r = rand_next();
			w[i[2:0]] = r[15:0];
		end
		// Top half of addr carries the side bit
		w[3][15] = side;
		exp.flags   = {w[1], w[0]};
		exp.addr    = {w[3], w[2]};
		exp.compare = {w[5], w[4]};
		exp.replace = {w[7], w[6]};
		dl_begin(IDX_CODE);
		gen0 = gen_pulses;
		mcd0 = mcd_pulses;
		clr0 = clear_pulses;
		for (i = 0; i < 8; i++) begin
			dl_write(`MCD_DL_ADDR_W'(i * 2), w[i[2:0]]);
			if (i == 0) begin
				@(negedge clk_sys);
				check_bit("cheat", 1'b1, code_clear);
			end
		end
		wait_level("cheat", side ? "code_mcd_stb" : "code_gen_stb",
			side ? SEL_MCD : SEL_GEN, 1'b1, 3);
		check_code("cheat", exp, code);
		repeat (3) @(negedge clk_sys);
		dl_end();
		check_count("cheat", side ? 0 : 1, gen_pulses - gen0);
		check_count("cheat", side ? 1 : 0, mcd_pulses - mcd0);
		check_count("cheat", 1, clear_pulses - clr0);
	endtask

	task automatic test_header(input logic [7:0] letter, input region_e exp);
		logic [31:0] r;
		r = rand_next();
		dl_begin(IDX_CART);
		// Letter at a neighbouring address must be ignored
		dl_write(`MCD_DL_ADDR_W'('h1EE), 16'h4A4A);
		dl_write(`MCD_DL_ADDR_W'(`MCD_HDR_REGION_ADDR), {r[15:8], letter});
		wait_level("header", "region_set", SEL_RSET, 1'b1, 2);
		check_region("header", exp, region_req);
		dl_end();
		wait_level("header", "region_set", SEL_RSET, 1'b0, 2);
	endtask

	task automatic press_key(input logic [8:0] key, input logic pressed, input region_e exp);
		@(posedge clk_sys);
		ps2_key <= {~ps2_key[`MCD_PS2_W-1], pressed, key};
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_region("hotkeys", exp, region_req);
		check_bit("hotkeys", pressed, region_set);
	endtask

	task automatic test_hotkeys();
		press_key(`MCD_KEY_F1, 1'b1, REGION_JP);
		press_key(`MCD_KEY_F1, 1'b0, REGION_JP);
		press_key(`MCD_KEY_F2, 1'b1, REGION_US);
		press_key(`MCD_KEY_F2, 1'b0, REGION_US);
		press_key(`MCD_KEY_F3, 1'b1, REGION_EU);
		press_key(`MCD_KEY_F3, 1'b0, REGION_EU);
	endtask

	task automatic test_cd_link();
		logic [31:0] r1;
		logic [31:0] r2;
		logic [39:0] stat;
		logic [39:0] comm;
		logic        dm;
		logic        tog;
		int          round;
		int          width;
		tog = 1'b0;
		for (round = 0; round < 2; round++) begin
			r1 = rand_next();
			r2 = rand_next();
			stat = {r1[7:0], r2};
			dm = r1[8];
			@(posedge clk_sys);
			cd_out <= {~cd_out[`MCD_CD_LINK_W-1], 7'h00, dm, stat};
			wait_level("cd_link", "cdd_rec", SEL_REC, 1'b1, 3);
			check_stat("cd_link", stat, cdd_stat);
			check_bit("cd_link", dm, cdd_dm);
			pulse_width(SEL_REC, width);
			check_count("cd_link", `MCD_HOLD_CYCLES + 1, width);

			// Command back to the host
			r1 = rand_next();
			r2 = rand_next();
			comm = {r1[7:0], r2};
			tog = ~tog;
			@(posedge clk_sys);
			cdd_comm <= comm;
			cdd_send <= 1'b1;
			@(posedge clk_sys);
			cdd_send <= 1'b0;
			@(negedge clk_sys);
			check_link("cd_link", {tog, 8'h00, comm}, cd_in);
		end
	endtask

	task automatic test_stretch();
		logic [31:0] r;
		int          width;
		r = rand_next();
		dl_begin(IDX_CDC_DAT);
		dl_write('0, r[15:0]);
		dl_write(`MCD_DL_ADDR_W'(2), r[31:16]);
		wait_level("stretch", "cdc_dat_wr", SEL_DAT, 1'b1, 2);
		check_word("stretch", r[31:16], cdc_data);
		check_bit("stretch", 1'b0, cdc_sc_wr);
		pulse_width(SEL_DAT, width);
		check_count("stretch", `MCD_HOLD_CYCLES + 1, width);
		dl_end();

		r = rand_next();
		dl_begin(IDX_CDC_SUB);
		dl_write('0, r[15:0]);
		wait_level("stretch", "cdc_sc_wr", SEL_SC, 1'b1, 2);
		check_word("stretch", r[15:0], cdc_data);
		check_bit("stretch", 1'b0, cdc_dat_wr);
		pulse_width(SEL_SC, width);
		check_count("stretch", `MCD_HOLD_CYCLES + 1, width);
		dl_end();
	endtask

	// New resolution must wait for the end of vblank
	task automatic aspect_row(input video_res_e old_res, input video_res_e new_res);
		@(posedge clk_sys);
		resolution <= new_res;
		@(negedge clk_sys);
		expect_ratio(old_res, 1'b0, 1'b0);
		@(posedge clk_sys);
		vblank <= 1'b1;
		@(negedge clk_sys);
		expect_ratio(old_res, 1'b0, 1'b0);
		@(posedge clk_sys);
		vblank <= 1'b0;
		@(negedge clk_sys);
		expect_ratio(old_res, 1'b0, 1'b0);
		@(negedge clk_sys);
		expect_ratio(new_res, 1'b0, 1'b0);
		@(posedge clk_sys);
		ar_corrected <= 1'b1;
		@(negedge clk_sys);
		expect_ratio(new_res, 1'b1, 1'b0);
		@(posedge clk_sys);
		wide_169 <= 1'b1;
		@(negedge clk_sys);
		expect_ratio(new_res, 1'b1, 1'b1);
		@(posedge clk_sys);
		wide_169     <= 1'b0;
		ar_corrected <= 1'b0;
	endtask

	task automatic test_aspect();
		aspect_row(RES_H32_V28, RES_H40_V30);
		aspect_row(RES_H40_V30, RES_H32_V30);
		aspect_row(RES_H32_V30, RES_H40_V28);
		aspect_row(RES_H40_V28, RES_H32_V28);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		init_inputs();
		wait (rst_n === 1'b1);
		@(posedge clk_sys);
		check_reset_state();
		test_cheat(1'b0);
		test_cheat(1'b1);
		test_header("U", REGION_US);
		test_header("J", REGION_JP);
		test_header("X", REGION_EU);
		test_hotkeys();
		test_cd_link();
		test_stretch();
		test_aspect();
		repeat (4) @(posedge clk_sys);
		print_counts();
		if (value_errors == 0 && other_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
hw/mcd_pkg.sv
hw/cheat_code_loader.sv
hw/region_select.sv
hw/cdd_link.sv
hw/cdc_write_stretch.sv
hw/aspect_ratio.sv
hw/mcd_host_bridge.sv
tests/tb_clock.sv
tests/tb_mcd_host_bridge.sv
